// File: Makefile
# Verilator simulation of the pipelined AES-128 core

VERILATOR ?= verilator
FILELIST  ?= aesPipe.f
TOP       ?= aesPipeTb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Simulation PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: aesPipe.f
+incdir+include
source/aesPkg.sv
source/aesKeyLoad.sv
source/aesRound.sv
source/aesFinalRound.sv
source/aesPipe.sv
verif/aesPipe_sva.sv
verif/aesPipeTb.sv

// File: include/aes_defs.svh
`ifndef AES_DEFS_SVH
`define AES_DEFS_SVH

// data path widths
`define AES_BLOCK_BITS 128
`define AES_KEY_BITS   128
`define AES_WORD_BITS  32
`define AES_BYTE_BITS  8

// cipher rounds for a 128-bit key
`define AES_ROUNDS     10

// key load stage plus one stage per round
`define AES_LATENCY    (`AES_ROUNDS + 1)

`endif

// File: source/aesFinalRound.sv
`timescale 1ns/10ps
`include "aes_defs.svh"

module aesFinalRound (
    input  logic            clk,
    input  logic            rst,
    input  logic            advance,
    input  logic            prevValid,
    input  aesPkg::aesBlock prevState,
    input  aesPkg::aesKey   prevKey,
    output logic            outValid,
    output aesPkg::aesBlock outData
);

    import aesPkg::*;

    aesKey   lastKey;
    aesBlock cipherText;

    assign lastKey = nextRoundKey(prevKey, `AES_ROUNDS);

    // no mixColumns in the last round
    assign cipherText = shiftRows(subBlock(prevState)) ^ lastKey;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            outValid <= 1'b0;
        end else if (advance) begin
            outValid <= prevValid;
        end
    end

    // holds while the sink stalls
    always_ff @(posedge clk) begin
        if (advance) begin
            outData <= cipherText;
        end
    end

endmodule

// File: source/aesKeyLoad.sv
`timescale 1ns/10ps

module aesKeyLoad (
    input  logic            clk,
    input  logic            rst,
    input  logic            advance,
    input  logic            inValid,
    input  aesPkg::aesBlock inData,
    input  aesPkg::aesKey   inKey,
    output logic            stageValid,
    output aesPkg::aesBlock stageState,
    output aesPkg::aesKey   stageKey
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stageValid <= 1'b0;
        end else if (advance) begin
            stageValid <= inValid;
        end
    end

    // round 0 is a plain key addition
    always_ff @(posedge clk) begin
        if (advance) begin
            stageState <= inData ^ inKey;
            stageKey   <= inKey;
        end
    end

endmodule

// File: source/aesPipe.sv
`timescale 1ns/10ps
`include "aes_defs.svh"

module aesPipe (
    input  logic            clk,
    input  logic            rst,
    input  logic            inValid,
    output logic            inReady,
    input  aesPkg::aesBlock inData,
    input  aesPkg::aesKey   inKey,
    output logic            outValid,
    input  logic            outReady,
    output aesPkg::aesBlock outData
);

    import aesPkg::*;

    logic    advance;
    // index 0 is the key load stage, index i is round i
    logic    stageValid [0:`AES_ROUNDS-1];
    aesBlock stageState [0:`AES_ROUNDS-1];
    aesKey   stageKey   [0:`AES_ROUNDS-1];

    // whole pipe moves together, or not at all
    assign advance = !outValid || outReady;
    assign inReady = advance;

    aesKeyLoad keyLoad (
        .clk        (clk),
        .rst        (rst),
        .advance    (advance),
        .inValid    (inValid),
        .inData     (inData),
        .inKey      (inKey),
        .stageValid (stageValid[0]),
        .stageState (stageState[0]),
        .stageKey   (stageKey[0])
    );

    for (genvar r = 1; r < `AES_ROUNDS; r++) begin : gRound
        aesRound #(
            .ROUND_INDEX (r)
        ) round (
            .clk        (clk),
            .rst        (rst),
            .advance    (advance),
            .prevValid  (stageValid[r-1]),
            .prevState  (stageState[r-1]),
            .prevKey    (stageKey[r-1]),
            .stageValid (stageValid[r]),
            .stageState (stageState[r]),
            .stageKey   (stageKey[r])
        );
    end

    aesFinalRound finalRound (
        .clk       (clk),
        .rst       (rst),
        .advance   (advance),
        .prevValid (stageValid[`AES_ROUNDS-1]),
        .prevState (stageState[`AES_ROUNDS-1]),
        .prevKey   (stageKey[`AES_ROUNDS-1]),
        .outValid  (outValid),
        .outData   (outData)
    );

endmodule

// File: source/aesPkg.sv
`include "aes_defs.svh"

package aesPkg;

    typedef logic [`AES_BYTE_BITS-1:0]  aesByte;
    typedef logic [`AES_WORD_BITS-1:0]  aesWord;
    // byte 0 of the state sits in the top byte
    typedef logic [`AES_BLOCK_BITS-1:0] aesBlock;
    typedef logic [`AES_KEY_BITS-1:0]   aesKey;

    // forward s-box, indexed by input byte
    localparam aesByte SBOX [256] = '{
        8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
        8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
        8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
        8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
        8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
        8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
        8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
        8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
        8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
        8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
        8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
        8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
        8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
        8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
        8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
        8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
        8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
        8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
        8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
        8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
        8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
        8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
        8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
        8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
        8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
        8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
        8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
        8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
        8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
        8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
        8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
        8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
    };

    function automatic aesByte subByte(input aesByte b);
        return SBOX[b];
    endfunction

    // multiply by x, reduce by the AES polynomial
    function automatic aesByte xtime(input aesByte b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic aesBlock subBlock(input aesBlock s);
        aesBlock r;
        for (int i = 0; i < 16; i++) begin
            r[i*8 +: 8] = subByte(s[i*8 +: 8]);
        end
        return r;
    endfunction

    // row r rotates left by r columns
    function automatic aesBlock shiftRows(input aesBlock s);
        aesBlock r;
        int src;
        for (int c = 0; c < 4; c++) begin
            for (int row = 0; row < 4; row++) begin
                src = 4 * ((c + row) % 4) + row;
                r[127 - 8 * (4 * c + row) -: 8] = s[127 - 8 * src -: 8];
            end
        end
        return r;
    endfunction

    function automatic aesBlock mixColumns(input aesBlock s);
        aesBlock r;
        aesWord col;
        aesByte a [4];
        for (int c = 0; c < 4; c++) begin
            col = s[127 - 32 * c -: 32];
            a[0] = col[31:24];
            a[1] = col[23:16];
            a[2] = col[15:8];
            a[3] = col[7:0];
            // 3*x is x ^ 2*x
            r[127 - 32 * c -: 32] = {
                xtime(a[0]) ^ xtime(a[1]) ^ a[1] ^ a[2] ^ a[3],
                a[0] ^ xtime(a[1]) ^ xtime(a[2]) ^ a[2] ^ a[3],
                a[0] ^ a[1] ^ xtime(a[2]) ^ xtime(a[3]) ^ a[3],
                xtime(a[0]) ^ a[0] ^ a[1] ^ a[2] ^ xtime(a[3])
            };
        end
        return r;
    endfunction

    function automatic aesWord rotWord(input aesWord w);
        return {w[23:0], w[31:24]};
    endfunction

    function automatic aesWord subWord(input aesWord w);
        return {subByte(w[31:24]), subByte(w[23:16]), subByte(w[15:8]), subByte(w[7:0])};
    endfunction

    function automatic aesByte rconFor(input int round);
        case (round)
            1:       return 8'h01;
            2:       return 8'h02;
            3:       return 8'h04;
            4:       return 8'h08;
            5:       return 8'h10;
            6:       return 8'h20;
            7:       return 8'h40;
            8:       return 8'h80;
            9:       return 8'h1b;
            10:      return 8'h36;
            default: return 8'h00;
        endcase
    endfunction

    // one step of the key schedule, four words at a time
    function automatic aesKey nextRoundKey(input aesKey k, input int round);
        aesWord w [4];
        aesWord t;
        t = subWord(rotWord(k[31:0])) ^ {rconFor(round), 24'h000000};
        w[0] = k[127:96] ^ t;
        w[1] = k[95:64] ^ w[0];
        w[2] = k[63:32] ^ w[1];
        w[3] = k[31:0] ^ w[2];
        return {w[0], w[1], w[2], w[3]};
    endfunction

endpackage

// File: source/aesRound.sv
`timescale 1ns/10ps

module aesRound #(
    parameter int ROUND_INDEX = 1
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            advance,
    input  logic            prevValid,
    input  aesPkg::aesBlock prevState,
    input  aesPkg::aesKey   prevKey,
    output logic            stageValid,
    output aesPkg::aesBlock stageState,
    output aesPkg::aesKey   stageKey
);

    import aesPkg::*;

    aesKey   roundKey;
    aesBlock roundState;

    // key travels with its block, so every stage can hold a different key
    assign roundKey = nextRoundKey(prevKey, ROUND_INDEX);

    assign roundState = mixColumns(shiftRows(subBlock(prevState))) ^ roundKey;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stageValid <= 1'b0;
        end else if (advance) begin
            stageValid <= prevValid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            stageState <= roundState;
            stageKey   <= roundKey;
        end
    end

endmodule

// File: verif/aesPipeTb.sv
`timescale 1ns/10ps
`include "aes_defs.svh"

module aesPipeTb;

    import aesPkg::*;

    localparam int RESET_CYCLES  = 8;
    localparam int STREAM_BLOCKS = 150;
    localparam int DRAIN_LIMIT   = `AES_LATENCY + 4;
    localparam int MAX_CYCLES    = 300 * (`AES_LATENCY + 4) + RESET_CYCLES;

    logic    clk;
    logic    rst;
    logic    inValid;
    logic    inReady;
    aesBlock inData;
    aesKey   inKey;
    logic    outValid;
    logic    outReady;
    aesBlock outData;

    // expected ciphertexts in acceptance order
    aesBlock modelQ [$];
    integer  seed;
    int      cycleCount;
    int      checkedCount;
    int      dataErrors;
    int      protocolErrors;
    string   testName;
    logic    katMode;
    aesBlock katExpect;

    aesPipe i_dut (
        .clk      (clk),
        .rst      (rst),
        .inValid  (inValid),
        .inReady  (inReady),
        .inData   (inData),
        .inKey    (inKey),
        .outValid (outValid),
        .outReady (outReady),
        .outData  (outData)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // one closing line with all error counts
    task automatic printCounts(input int extraErrors);
        $display("Result: %0d checked, %0d data errors, %0d protocol errors, %0d sva errors",
                 checkedCount, dataErrors, protocolErrors + extraErrors, i_dut.i_sva.failCount);
    endtask

    initial begin
        repeat (MAX_CYCLES) @(posedge clk);
        $display("Error: run did not finish within %0d cycles", MAX_CYCLES);
        printCounts(1);
        $display("Simulation FAILED");
        $finish;
    end

    // FIPS-197 cipher, one round at a time
    function automatic aesBlock encryptModel(input aesBlock pt, input aesKey key);
        aesBlock s;
        aesKey   k;
        s = pt ^ key;
        k = key;
        for (int r = 1; r <= `AES_ROUNDS; r++) begin
            k = nextRoundKey(k, r);
            s = shiftRows(subBlock(s));
            if (r < `AES_ROUNDS) begin
                s = mixColumns(s);
            end
            s = s ^ k;
        end
        return s;
    endfunction

    function automatic aesBlock randomBlock();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    // drive on the falling edge, then look at what the next rising edge will transfer
    task automatic driveCycle(input logic v, input aesBlock d, input aesKey k,
                              input logic rdy, output logic acc, output logic dlv);
        aesBlock expected;
        @(negedge clk);
        cycleCount++;
        inValid  = v;
        inData   = d;
        inKey    = k;
        outReady = rdy;
        #1;
        acc = v && inReady;
        dlv = outValid && outReady;
        assert (!(outValid && !outReady && inReady)) else begin
            $display("Error: inReady high while the output is stalled in %s", testName);
            protocolErrors++;
        end
        if (acc) begin
            modelQ.push_back(katMode ? katExpect : encryptModel(d, k));
        end
        if (dlv) begin
            assert (modelQ.size() > 0) else begin
                $display("Error: %s produced an output with no block outstanding", testName);
                protocolErrors++;
            end
            if (modelQ.size() > 0) begin
                expected = modelQ.pop_front();
                checkedCount++;
                assert (outData === expected) else begin
                    $display("Fail %s: expected %h, actual %h", testName, expected, outData);
                    dataErrors++;
                end
            end
        end
    endtask

    task automatic drain();
        logic acc;
        logic dlv;
        int   waited;
        waited = 0;
        while (modelQ.size() > 0 && waited < DRAIN_LIMIT) begin
            driveCycle(1'b0, '0, '0, 1'b1, acc, dlv);
            waited++;
        end
        assert (modelQ.size() == 0) else begin
            $display("Error: %s left %0d blocks undelivered", testName, modelQ.size());
            protocolErrors++;
        end
        // a few idle cycles catch duplicated outputs
        repeat (3) driveCycle(1'b0, '0, '0, 1'b1, acc, dlv);
    endtask

    task automatic knownAnswer();
        aesKey   key;
        aesBlock pt;
        aesBlock ct;
        logic    acc;
        logic    dlv;
        testName = "known answer";
        key = 128'h000102030405060708090a0b0c0d0e0f;
        pt  = 128'h00112233445566778899aabbccddeeff;
        ct  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
        assert (encryptModel(pt, key) === ct) else begin
            $display("Fail %s model: expected %h, actual %h", testName, ct,
                     encryptModel(pt, key));
            dataErrors++;
        end
        // DUT is held to the published vector, not to the model
        katMode   = 1'b1;
        katExpect = ct;
        acc = 1'b0;
        while (!acc) begin
            driveCycle(1'b1, pt, key, 1'b1, acc, dlv);
        end
        katMode = 1'b0;
        drain();
    endtask

    task automatic sendStream(input int n, input logic randomReady, input string name);
        aesBlock d;
        aesKey   k;
        logic    rdy;
        logic    acc;
        logic    dlv;
        int      sent;
        int      r;
        testName = name;
        sent = 0;
        d = randomBlock();
        k = randomBlock();
        while (sent < n) begin
            r = $random(seed);
            rdy = randomReady ? r[0] : 1'b1;
            driveCycle(1'b1, d, k, rdy, acc, dlv);
            if (acc) begin
                sent++;
                d = randomBlock();
                k = randomBlock();
            end
        end
        drain();
    endtask

    task automatic checkLatency(input int blocks);
        aesBlock d;
        aesKey   k;
        logic    acc;
        logic    dlv;
        int      acceptIdx;
        int      waited;
        testName = "fixed latency";
        for (int b = 0; b < blocks; b++) begin
            d = randomBlock();
            k = randomBlock();
            acc = 1'b0;
            while (!acc) begin
                driveCycle(1'b1, d, k, 1'b1, acc, dlv);
            end
            acceptIdx = cycleCount;
            dlv = 1'b0;
            waited = 0;
            while (!dlv && waited < DRAIN_LIMIT) begin
                driveCycle(1'b0, '0, '0, 1'b1, acc, dlv);
                waited++;
            end
            assert (dlv) else begin
                $display("Error: block in %s never reached the output", testName);
                protocolErrors++;
            end
            if (dlv) begin
                assert (cycleCount - acceptIdx == `AES_LATENCY) else begin
                    $display("Fail %s: expected %0d, actual %0d", testName, `AES_LATENCY,
                             cycleCount - acceptIdx);
                    dataErrors++;
                end
            end
            drain();
        end
    endtask

    task automatic resetMidStream();
        aesBlock d;
        aesKey   k;
        logic    acc;
        logic    dlv;
        int      sent;
        testName = "reset mid-stream";
        sent = 0;
        d = randomBlock();
        k = randomBlock();
        // enough blocks that the output is busy when reset hits
        while (sent < 14) begin
            driveCycle(1'b1, d, k, 1'b1, acc, dlv);
            if (acc) begin
                sent++;
                d = randomBlock();
                k = randomBlock();
            end
        end
        @(negedge clk);
        inValid = 1'b0;
        rst     = 1'b1;
        #1;
        assert (!outValid) else begin
            $display("Error: outValid stayed high after reset was asserted");
            protocolErrors++;
        end
        // blocks in flight are gone
        modelQ.delete();
        repeat (3) @(negedge clk);
        rst = 1'b0;
        sendStream(10, 1'b0, "after reset");
    endtask

    initial begin
        seed           = 32'h40ae_711b;
        cycleCount     = 0;
        checkedCount   = 0;
        dataErrors     = 0;
        protocolErrors = 0;
        katMode        = 1'b0;
        katExpect      = '0;
        testName       = "reset";
        rst      = 1'b1;
        inValid  = 1'b0;
        inData   = '0;
        inKey    = '0;
        outReady = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        knownAnswer();
        sendStream(STREAM_BLOCKS, 1'b0, "random stream");
        checkLatency(3);
        sendStream(STREAM_BLOCKS, 1'b1, "back-pressure");
        resetMidStream();

        printCounts(0);
        if (dataErrors == 0 && protocolErrors == 0 && i_dut.i_sva.failCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: verif/aesPipe_sva.sv
`timescale 1ns/10ps

module aesPipeSva (
    input logic            clk,
    input logic            rst,
    input logic            inReady,
    input logic            outValid,
    input logic            outReady,
    input aesPkg::aesBlock outData
);

    // failed assertions so far
    int failCount = 0;

    // output register is empty during reset
    resetClearsOutput: assert property (
        @(posedge clk) rst |-> !outValid
    ) else begin
        failCount++;
        $error("outValid high while rst is asserted");
    end

    // a stalled output holds its block
    stallHoldsOutput: assert property (
        @(posedge clk) disable iff (rst)
        (outValid && !outReady) |=> (outValid && $stable(outData))
    ) else begin
        failCount++;
        $error("output changed while the sink was stalling");
    end

    // the whole pipe moves only when the output slot can drain
    readyFollowsOutput: assert property (
        @(posedge clk) disable iff (rst)
        inReady == (!outValid || outReady)
    ) else begin
        failCount++;
        $error("inReady does not match the output handshake");
    end

endmodule

bind aesPipe aesPipeSva i_sva (
    .clk      (clk),
    .rst      (rst),
    .inReady  (inReady),
    .outValid (outValid),
    .outReady (outReady),
    .outData  (outData)
);
